/* axi_wr_defs.svh */
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// AXI side widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)
`define AXI_ID_W 4

// Byte lane bits within one data word, log2 of the data bytes
`define AXI_LANE_W 2

// Memory word address
`define BRAM_ADDR_W 12

// Outstanding bursts, which is also the response queue depth
`define AXI_OS_WR 4
`define AXI_OS_PTR_W 2

`endif

/* axi_chan_pkg.sv */
`default_nettype none

`include "axi_wr_defs.svh"

package axi_chan_pkg;

  // Burst type encoding as on AWBURST
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Write address channel
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    burst_e                 burst;
  } aw_chan_t;

  // Write data channel, no WLAST
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } w_chan_t;

  // Write response, BRESP is always OKAY
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
  } b_chan_t;

endpackage

`default_nettype wire

/* bram_port_pkg.sv */
`default_nettype none

`include "axi_wr_defs.svh"

package bram_port_pkg;

  // Word index and lane within the word
  typedef struct packed {
    logic [`AXI_ADDR_W-`AXI_LANE_W-1:0] idx;
    logic [`AXI_LANE_W-1:0]             lane;
  } axi_word_addr_t;

  // Same 32 bits, seen as a byte address or as word index plus lane
  typedef union packed {
    logic [`AXI_ADDR_W-1:0] byte_addr;
    axi_word_addr_t         word;
  } axi_addr_u;

  // Block memory write port
  typedef struct packed {
    logic                    en;
    logic [`BRAM_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0]  data;
    logic [`AXI_STRB_W-1:0]  strb;
  } bram_wr_t;

endpackage

`default_nettype wire

/* axi_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_ctrl (
  input  wire logic S_ACLK,
  input  wire logic S_ARESETN,
  input  wire logic aw_valid,
  input  wire logic w_valid,
  input  wire logic last_beat,
  input  wire logic q_full,
  output logic      aw_ready,
  output logic      w_ready,
  output logic      addr_load,
  output logic      beat_fire,
  output logic      resp_push
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_DATA = 2'b01,
    ST_RESP = 2'b10
  } state_e;

  state_e state_q;
  state_e state_d;

  // One burst at a time, new AW only when the ID queue has room
  assign aw_ready  = (state_q == ST_IDLE) && !q_full;
  assign w_ready   = (state_q == ST_DATA);
  assign addr_load = aw_valid && aw_ready;
  assign beat_fire = w_valid && w_ready;
  assign resp_push = (state_q == ST_RESP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (addr_load) begin
          state_d = ST_DATA;
        end
      end
      ST_DATA: begin
        // Beat counter decides the end of the burst
        if (beat_fire && last_beat) begin
          state_d = ST_RESP;
        end
      end
      ST_RESP: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // AW master holds valid until the address is taken
  a_aw_valid_hold: assert property (
    @(posedge S_ACLK) disable iff (S_ARESETN)
    (aw_valid && !aw_ready) |=> aw_valid
  );

  // W master holds valid until the beat is taken
  a_w_valid_hold: assert property (
    @(posedge S_ACLK) disable iff (S_ARESETN)
    (w_valid && !w_ready) |=> w_valid
  );

endmodule

`default_nettype wire

/* axi_wr_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_wr_addr_gen
  import axi_chan_pkg::*;
  import bram_port_pkg::*;
(
  input  wire logic     S_ACLK,
  input  wire logic     S_ARESETN,
  input  wire aw_chan_t aw,
  input  wire logic     addr_load,
  input  wire logic     beat_fire,
  input  wire w_chan_t  w,
  output logic          last_beat,
  output bram_wr_t      bram_wr
);

  axi_addr_u  addr_q;
  logic [7:0] beat_bytes_q;
  logic [7:0] len_q;
  logic [7:0] cnt_q;
  burst_e     burst_q;

  logic [`AXI_ADDR_W-1:0] step;
  logic [`AXI_ADDR_W-1:0] wrap_len;
  logic [`AXI_ADDR_W-1:0] wrap_base;
  logic [`AXI_ADDR_W-1:0] wrap_last;
  logic [`AXI_ADDR_W-1:0] addr_next;

  // Wrap window is beat size times beat count, always a power of two
  always_comb begin
    step      = `AXI_ADDR_W'(beat_bytes_q);
    wrap_len  = step * (`AXI_ADDR_W'(len_q) + `AXI_ADDR_W'(1));
    wrap_base = addr_q.byte_addr & ~(wrap_len - `AXI_ADDR_W'(1));
    wrap_last = wrap_base + wrap_len - step;
    case (burst_q)
      BURST_FIXED: addr_next = addr_q.byte_addr;
      BURST_WRAP: begin
        if (addr_q.byte_addr == wrap_last) begin
          addr_next = wrap_base;
        end else begin
          addr_next = addr_q.byte_addr + step;
        end
      end
      default: addr_next = addr_q.byte_addr + step;
    endcase
  end

  // Burst payload
  always_ff @(posedge S_ACLK) begin
    if (addr_load) begin
      addr_q.byte_addr <= aw.addr;
      beat_bytes_q     <= 8'd1 << aw.size;
      len_q            <= aw.len;
    end else if (beat_fire) begin
      addr_q.byte_addr <= addr_next;
    end
  end

  // Beat counter and burst type
  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      cnt_q   <= 8'd0;
      burst_q <= BURST_FIXED;
    end else if (addr_load) begin
      cnt_q   <= aw.len;
      burst_q <= aw.burst;
    end else if (beat_fire && (cnt_q != 8'd0)) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  assign last_beat = (cnt_q == 8'd0);

  // Narrow beats share a word until the byte address crosses into the next one
  assign bram_wr.en   = beat_fire;
  assign bram_wr.addr = addr_q.word.idx[`BRAM_ADDR_W-1:0];
  assign bram_wr.data = w.data;
  assign bram_wr.strb = w.strb;

  a_wrap_len: assert property (
    @(posedge S_ACLK) disable iff (S_ARESETN)
    (addr_load && (aw.burst == BURST_WRAP)) |-> (aw.len inside {8'd1, 8'd3, 8'd7, 8'd15})
  );

endmodule

`default_nettype wire

/* axi_wr_resp_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_wr_resp_queue
  import axi_chan_pkg::*;
(
  input  wire logic     S_ACLK,
  input  wire logic     S_ARESETN,
  input  wire aw_chan_t aw,
  input  wire logic     addr_load,
  input  wire logic     resp_push,
  input  wire logic     b_ready,
  output logic          q_full,
  output b_chan_t       b,
  output logic          b_valid
);

  logic [`AXI_ID_W-1:0]     id_mem [`AXI_OS_WR];
  logic [`AXI_OS_PTR_W-1:0] wr_ptr_q;
  logic [`AXI_OS_PTR_W-1:0] rd_ptr_q;
  logic [`AXI_OS_PTR_W:0]   occ_q;
  logic [`AXI_OS_PTR_W:0]   pend_q;
  logic                     b_fire;

  assign b_fire  = b_valid && b_ready;
  assign q_full  = (occ_q == (`AXI_OS_PTR_W + 1)'(`AXI_OS_WR));
  assign b_valid = (pend_q != '0);
  assign b.id    = id_mem[rd_ptr_q];

  // IDs enter at AW accept, in issue order
  always_ff @(posedge S_ACLK) begin
    if (addr_load) begin
      id_mem[wr_ptr_q] <= aw.id;
    end
  end

  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      occ_q    <= '0;
    end else begin
      if (addr_load) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (b_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({addr_load, b_fire})
        2'b10:   occ_q <= occ_q + 1'b1;
        2'b01:   occ_q <= occ_q - 1'b1;
        default: occ_q <= occ_q;
      endcase
    end
  end

  // Responses ready to go out, i.e. bursts whose data has all arrived
  always_ff @(posedge S_ACLK) begin
    if (S_ARESETN) begin
      pend_q <= '0;
    end else begin
      case ({resp_push, b_fire})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
    end
  end

  // A response can only exist for an ID still held in the queue
  a_pend_le_occ: assert property (
    @(posedge S_ACLK) disable iff (S_ARESETN)
    pend_q <= occ_q
  );

endmodule

`default_nettype wire

/* axi_bram_write.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_bram_write
  import axi_chan_pkg::*;
  import bram_port_pkg::*;
(
  input  wire logic     S_ACLK,
  input  wire logic     S_ARESETN,
  input  wire aw_chan_t aw,
  input  wire logic     aw_valid,
  output logic          aw_ready,
  input  wire w_chan_t  w,
  input  wire logic     w_valid,
  output logic          w_ready,
  output b_chan_t       b,
  output logic          b_valid,
  input  wire logic     b_ready,
  output bram_wr_t      bram_wr
);

  logic addr_load;
  logic beat_fire;
  logic resp_push;
  logic last_beat;
  logic q_full;

  axi_wr_ctrl i_ctrl (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .aw_valid  (aw_valid),
    .w_valid   (w_valid),
    .last_beat (last_beat),
    .q_full    (q_full),
    .aw_ready  (aw_ready),
    .w_ready   (w_ready),
    .addr_load (addr_load),
    .beat_fire (beat_fire),
    .resp_push (resp_push)
  );

  axi_wr_addr_gen i_addr_gen (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .aw        (aw),
    .addr_load (addr_load),
    .beat_fire (beat_fire),
    .w         (w),
    .last_beat (last_beat),
    .bram_wr   (bram_wr)
  );

  axi_wr_resp_queue i_resp_queue (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .aw        (aw),
    .addr_load (addr_load),
    .resp_push (resp_push),
    .b_ready   (b_ready),
    .q_full    (q_full),
    .b         (b),
    .b_valid   (b_valid)
  );

endmodule

`default_nettype wire

/* tb_axi_bram_write.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_defs.svh"

module tb_axi_bram_write
  import axi_chan_pkg::*;
  import bram_port_pkg::*;
();

  localparam int unsigned CYCLE_LIMIT = 4000;

  logic     S_ACLK;
  logic     S_ARESETN;
  aw_chan_t aw;
  logic     aw_valid;
  logic     aw_ready;
  w_chan_t  w;
  logic     w_valid;
  logic     w_ready;
  b_chan_t  b;
  logic     b_valid;
  logic     b_ready;
  bram_wr_t bram_wr;

  logic [31:0]             lfsr_q;
  int                      val_errs;
  int                      other_errs;
  logic [`BRAM_ADDR_W-1:0] exp_addr[$];
  logic [`AXI_DATA_W-1:0]  exp_data[$];
  logic [`AXI_STRB_W-1:0]  exp_strb[$];
  logic [`AXI_ID_W-1:0]    exp_id[$];

  axi_bram_write i_dut (
    .S_ACLK    (S_ACLK),
    .S_ARESETN (S_ARESETN),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .bram_wr   (bram_wr)
  );

  initial begin
    S_ACLK = 1'b0;
    forever #50 S_ACLK = ~S_ACLK;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Expected byte address of the following beat
  function automatic logic [31:0] next_addr(input logic [31:0] addr, input logic [2:0] size,
                                            input logic [7:0] len, input burst_e burst);
    logic [31:0] beat;
    logic [31:0] total;
    logic [31:0] base;
    logic [31:0] nxt;
    beat  = 32'd1 << size;
    total = beat * (len + 32'd1);
    nxt   = addr + beat;
    if (burst == BURST_FIXED) begin
      nxt = addr;
    end else if (burst == BURST_WRAP) begin
      base = (addr / total) * total;
      if (nxt >= base + total) begin
        nxt = base;
      end
    end
    return nxt;
  endfunction

  task automatic do_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                          input logic [2:0] size, input burst_e burst);
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] gap;
    int          beat;
    a        = addr;
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = len;
    aw.size  = size;
    aw.burst = burst;
    aw_valid = 1'b1;
    exp_id.push_back(id);
    @(negedge S_ACLK);
    while (!aw_ready) @(negedge S_ACLK);
    @(posedge S_ACLK);
    #10;
    aw_valid = 1'b0;
    for (beat = 0; beat <= len; beat++) begin
      draw_bits(1, gap);
      if (gap[0]) begin
        @(posedge S_ACLK);
        #10;
      end
      draw_bits(32, d);
      draw_bits(4, s);
      w.data  = d;
      w.strb  = s[3:0];
      w_valid = 1'b1;
      exp_addr.push_back(a[`BRAM_ADDR_W+`AXI_LANE_W-1:`AXI_LANE_W]);
      exp_data.push_back(d);
      exp_strb.push_back(s[3:0]);
      a = next_addr(a, size, len, burst);
      @(negedge S_ACLK);
      while (!w_ready) @(negedge S_ACLK);
      @(posedge S_ACLK);
      #10;
      w_valid = 1'b0;
    end
  endtask

  // Compares memory writes and responses mid-cycle
  initial begin
    forever begin
      @(negedge S_ACLK);
      if (bram_wr.en === 1'b1) begin
        if (exp_addr.size() == 0) begin
          other_errs++;
          $display("Memory write seen with no beat expected");
        end else begin
          if (bram_wr.addr !== exp_addr[0]) begin
            val_errs++;
            $display("CHECK FAILED bram_wr.addr got %h exp %h", bram_wr.addr, exp_addr[0]);
          end
          if (bram_wr.data !== exp_data[0]) begin
            val_errs++;
            $display("CHECK FAILED bram_wr.data got %h exp %h", bram_wr.data, exp_data[0]);
          end
          if (bram_wr.strb !== exp_strb[0]) begin
            val_errs++;
            $display("CHECK FAILED bram_wr.strb got %h exp %h", bram_wr.strb, exp_strb[0]);
          end
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
          void'(exp_strb.pop_front());
        end
      end
      if (b_valid === 1'b1 && b_ready === 1'b1) begin
        if (exp_id.size() == 0) begin
          other_errs++;
          $display("Write response seen with no burst outstanding");
        end else begin
          if (b.id !== exp_id[0]) begin
            val_errs++;
            $display("CHECK FAILED b.id got %h exp %h", b.id, exp_id[0]);
          end
          void'(exp_id.pop_front());
        end
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge S_ACLK);
      cycles++;
    end
    $display("Timeout after %0d cycles, the bursts did not complete", CYCLE_LIMIT);
    $display("Errors: %0d value, %0d other", val_errs, other_errs + 1);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] len;
    logic [31:0] id;
    logic [31:0] total;
    int          i;
    lfsr_q     = 32'hc69b;
    val_errs   = 0;
    other_errs = 0;
    S_ARESETN  = 1'b1;
    aw         = '0;
    aw_valid   = 1'b0;
    w          = '0;
    w_valid    = 1'b0;
    b_ready    = 1'b1;
    repeat (2) @(posedge S_ACLK);
    #10;
    S_ARESETN = 1'b0;

    // Idle after reset, ready for a first burst
    @(negedge S_ACLK);
    if (aw_ready !== 1'b1) begin
      val_errs++;
      $display("CHECK FAILED aw_ready got %h exp %h", aw_ready, 1'b1);
    end
    if (w_ready !== 1'b0) begin
      val_errs++;
      $display("CHECK FAILED w_ready got %h exp %h", w_ready, 1'b0);
    end
    if (b_valid !== 1'b0) begin
      val_errs++;
      $display("CHECK FAILED b_valid got %h exp %h", b_valid, 1'b0);
    end
    if (bram_wr.en !== 1'b0) begin
      val_errs++;
      $display("CHECK FAILED bram_wr.en got %h exp %h", bram_wr.en, 1'b0);
    end
    @(posedge S_ACLK);
    #10;

    // Full size INCR
    for (i = 0; i < 8; i++) begin
      draw_bits(4, id);
      draw_bits(32, addr);
      draw_bits(4, len);
      do_burst(id[3:0], addr & ~32'd3, len[7:0], 3'd2, BURST_INCR);
    end

    // WRAP of 4, 8 and 16 beats, starting past the middle of the block
    for (i = 1; i <= 3; i++) begin
      len   = (32'd2 << i) - 32'd1;
      total = (len + 32'd1) * 32'd4;
      draw_bits(4, id);
      draw_bits(32, r);
      addr = (r & ~(total - 32'd1)) + total / 2 + 32'd4;
      do_burst(id[3:0], addr, len[7:0], 3'd2, BURST_WRAP);
    end

    // FIXED, then narrow INCR of byte and halfword size
    for (i = 0; i < 2; i++) begin
      draw_bits(4, id);
      draw_bits(32, addr);
      draw_bits(4, len);
      do_burst(id[3:0], addr & ~32'd3, len[7:0], 3'd2, BURST_FIXED);
    end
    draw_bits(4, id);
    draw_bits(32, addr);
    do_burst(id[3:0], addr, 8'd9, 3'd0, BURST_INCR);
    draw_bits(4, id);
    draw_bits(32, addr);
    do_burst(id[3:0], addr & ~32'd1, 8'd6, 3'd1, BURST_INCR);

    // Let the last response go out before holding the rest back
    while (exp_id.size() != 0) @(negedge S_ACLK);
    @(posedge S_ACLK);
    #10;

    // Responses held back until the queue is full
    b_ready = 1'b0;
    for (i = 0; i < `AXI_OS_WR; i++) begin
      draw_bits(4, id);
      draw_bits(32, addr);
      do_burst(id[3:0], addr & ~32'd3, 8'd1, 3'd2, BURST_INCR);
    end
    draw_bits(4, id);
    draw_bits(32, addr);
    fork
      do_burst(id[3:0], addr & ~32'd3, 8'd2, 3'd2, BURST_INCR);
      begin
        repeat (6) begin
          @(negedge S_ACLK);
          if (aw_ready !== 1'b0) begin
            val_errs++;
            $display("CHECK FAILED aw_ready got %h exp %h", aw_ready, 1'b0);
          end
        end
        @(posedge S_ACLK);
        #10;
        b_ready = 1'b1;
      end
    join

    while (exp_id.size() != 0 || exp_addr.size() != 0) @(negedge S_ACLK);
    repeat (2) @(posedge S_ACLK);
    $display("Errors: %0d value, %0d other", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
axi_chan_pkg.sv
bram_port_pkg.sv
axi_wr_ctrl.sv
axi_wr_addr_gen.sv
axi_wr_resp_queue.sv
axi_bram_write.sv
tb_axi_bram_write.sv

/* Bender.yml */
package:
  name: axi_bram_write

sources:
  - include_dirs:
      - .
    files:
      - axi_chan_pkg.sv
      - bram_port_pkg.sv
      - axi_wr_ctrl.sv
      - axi_wr_addr_gen.sv
      - axi_wr_resp_queue.sv
      - axi_bram_write.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_axi_bram_write.sv
